// ==== src/fiber_bank_geom_pkg.sv ====
`default_nettype none

package fiber_bank_geom_pkg;

    // --------------------------------------------------
    // address and data
    // --------------------------------------------------
    // word addressed, one word per line
    localparam int ADDR_W = 16;
    localparam int DATA_W = 16;

    // --------------------------------------------------
    // bank geometry
    // --------------------------------------------------
    localparam int SETS  = 16;
    localparam int WAYS  = 4;
    localparam int SET_W = $clog2(SETS);
    localparam int TAG_W = ADDR_W - SET_W;
    localparam int WAY_W = $clog2(WAYS);

    // --------------------------------------------------
    // srrip
    // --------------------------------------------------
    localparam int RRPV_W      = 2;
    localparam int RRPV_MAX    = 3;
    localparam int RRPV_INSERT = 2;

    // one bit per way
    typedef logic [WAYS-1:0] way_mask_t;

endpackage

`default_nettype wire

// ==== src/fiber_bank_proto_pkg.sv ====
`default_nettype none

package fiber_bank_proto_pkg;

    // pe request types
    typedef enum logic [1:0] {
        OP_FETCH   = 2'd0,
        OP_WRITE   = 2'd1,
        OP_CONSUME = 2'd2
    } req_op_t;

    // controller states
    typedef enum logic [2:0] {
        ST_IDLE      = 3'd0,
        ST_LOOKUP    = 3'd1,
        ST_WRITEBACK = 3'd2,
        ST_FILL      = 3'd3,
        ST_RESPOND   = 3'd4
    } bank_state_t;

endpackage

`default_nettype wire

// ==== src/srrip_victim.sv ====
`timescale 1ns/1ps
`default_nettype none

module srrip_victim (
    input  wire fiber_bank_geom_pkg::way_mask_t i_valid,
    input  wire [fiber_bank_geom_pkg::WAYS-1:0][fiber_bank_geom_pkg::RRPV_W-1:0] i_rrpv,
    output fiber_bank_geom_pkg::way_mask_t o_victim_way,
    output logic [fiber_bank_geom_pkg::RRPV_W-1:0] o_age_amount
);

    import fiber_bank_geom_pkg::*;

    logic [RRPV_W-1:0] max_rrpv;
    way_mask_t         first_invalid;
    way_mask_t         first_max;
    logic              all_valid;

    // largest rrpv in the set
    always_comb begin
        max_rrpv = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (i_rrpv[w] > max_rrpv) begin
                max_rrpv = i_rrpv[w];
            end
        end
    end

    // scan from the top so the lowest index wins
    always_comb begin
        first_invalid = '0;
        first_max     = '0;
        for (int w = WAYS - 1; w >= 0; w--) begin
            if (!i_valid[w]) begin
                first_invalid    = '0;
                first_invalid[w] = 1'b1;
            end
            if (i_rrpv[w] == max_rrpv) begin
                first_max    = '0;
                first_max[w] = 1'b1;
            end
        end
    end

    assign all_valid = &i_valid;

    // a free way needs no aging
    assign o_victim_way = all_valid ? first_max : first_invalid;
    assign o_age_amount = all_valid ? RRPV_W'(RRPV_MAX) - max_rrpv : '0;

endmodule

`default_nettype wire

// ==== src/tag_store.sv ====
`timescale 1ns/1ps
`default_nettype none

module tag_store (
    input  wire                                     i_clk,
    input  wire                                     i_reset,
    input  wire [fiber_bank_geom_pkg::SET_W-1:0]    i_set,
    input  wire [fiber_bank_geom_pkg::TAG_W-1:0]    i_tag,
    input  wire                                     i_install,
    input  wire fiber_bank_geom_pkg::way_mask_t     i_install_way,
    input  wire                                     i_install_dirty,
    input  wire                                     i_touch,
    input  wire                                     i_touch_dirty,
    input  wire                                     i_invalidate,
    input  wire                                     i_age,
    output logic                                    o_hit,
    output fiber_bank_geom_pkg::way_mask_t          o_hit_way,
    output fiber_bank_geom_pkg::way_mask_t          o_victim_way,
    output logic                                    o_victim_dirty,
    output logic [fiber_bank_geom_pkg::TAG_W-1:0]   o_victim_tag
);

    import fiber_bank_geom_pkg::*;

    logic [TAG_W-1:0]            tag_q   [SETS][WAYS];
    way_mask_t                   valid_q [SETS];
    way_mask_t                   dirty_q [SETS];
    logic [WAYS-1:0][RRPV_W-1:0] rrpv_q  [SETS];
    logic [RRPV_W-1:0]           age_amount;

    // --------------------------------------------------
    // lookup
    // --------------------------------------------------
    always_comb begin
        o_hit_way    = '0;
        o_victim_tag = '0;
        for (int w = 0; w < WAYS; w++) begin
            o_hit_way[w] = valid_q[i_set][w] && (tag_q[i_set][w] == i_tag);
            if (o_victim_way[w]) begin
                o_victim_tag = tag_q[i_set][w];
            end
        end
    end

    assign o_hit          = |o_hit_way;
    assign o_victim_dirty = |(dirty_q[i_set] & o_victim_way);

    srrip_victim u_victim (
        .i_valid      (valid_q[i_set]),
        .i_rrpv       (rrpv_q[i_set]),
        .o_victim_way (o_victim_way),
        .o_age_amount (age_amount)
    );

    // --------------------------------------------------
    // state updates
    // --------------------------------------------------
    // install beats aging on the same way, the rest of the set still ages
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            for (int s = 0; s < SETS; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
                rrpv_q[s]  <= '0;
            end
        end else begin
            for (int w = 0; w < WAYS; w++) begin
                if (i_install && i_install_way[w]) begin
                    valid_q[i_set][w] <= 1'b1;
                    dirty_q[i_set][w] <= i_install_dirty;
                    rrpv_q[i_set][w]  <= RRPV_W'(RRPV_INSERT);
                end else if (i_touch && o_hit_way[w]) begin
                    rrpv_q[i_set][w] <= '0;
                    if (i_touch_dirty) begin
                        dirty_q[i_set][w] <= 1'b1;
                    end
                end else if (i_invalidate && o_hit_way[w]) begin
                    valid_q[i_set][w] <= 1'b0;
                    dirty_q[i_set][w] <= 1'b0;
                end else if (i_age) begin
                    rrpv_q[i_set][w] <= rrpv_q[i_set][w] + age_amount;
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        for (int w = 0; w < WAYS; w++) begin
            if (i_install && i_install_way[w]) begin
                tag_q[i_set][w] <= i_tag;
            end
        end
    end

    // a tag never lives in two ways of one set
    a_hit_onehot0: assert property (
        @(posedge i_clk) disable iff (i_reset) $onehot0(o_hit_way)
    );

    // the srrip search always names exactly one way
    a_victim_onehot: assert property (
        @(posedge i_clk) disable iff (i_reset) $onehot(o_victim_way)
    );

endmodule

`default_nettype wire

// ==== src/data_store.sv ====
`timescale 1ns/1ps
`default_nettype none

module data_store (
    input  wire                                     i_clk,
    input  wire [fiber_bank_geom_pkg::SET_W-1:0]    i_set,
    input  wire                                     i_write,
    input  wire fiber_bank_geom_pkg::way_mask_t     i_write_way,
    input  wire [fiber_bank_geom_pkg::DATA_W-1:0]   i_write_data,
    input  wire fiber_bank_geom_pkg::way_mask_t     i_read_way,
    output logic [fiber_bank_geom_pkg::DATA_W-1:0]  o_read_data
);

    import fiber_bank_geom_pkg::*;

    logic [DATA_W-1:0] mem_q [SETS][WAYS];
    logic [WAY_W-1:0]  read_idx;

    // one-hot to index
    always_comb begin
        read_idx = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (i_read_way[w]) begin
                read_idx = WAY_W'(w);
            end
        end
    end

    assign o_read_data = mem_q[i_set][read_idx];

    always_ff @(posedge i_clk) begin
        if (i_write) begin
            for (int w = 0; w < WAYS; w++) begin
                if (i_write_way[w]) begin
                    mem_q[i_set][w] <= i_write_data;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/bank_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module bank_controller (
    input  wire                                     i_clk,
    input  wire                                     i_reset,
    input  wire                                     i_req_valid,
    input  wire fiber_bank_proto_pkg::req_op_t      i_req_op,
    input  wire [fiber_bank_geom_pkg::ADDR_W-1:0]   i_req_addr,
    input  wire [fiber_bank_geom_pkg::DATA_W-1:0]   i_req_data,
    input  wire                                     i_pe_ready,
    input  wire                                     i_dram_wr_ready,
    input  wire                                     i_dram_rd_valid,
    input  wire [fiber_bank_geom_pkg::DATA_W-1:0]   i_dram_rd_data,
    input  wire                                     i_hit,
    input  wire fiber_bank_geom_pkg::way_mask_t     i_hit_way,
    input  wire fiber_bank_geom_pkg::way_mask_t     i_victim_way,
    input  wire                                     i_victim_dirty,
    input  wire [fiber_bank_geom_pkg::TAG_W-1:0]    i_victim_tag,
    input  wire [fiber_bank_geom_pkg::DATA_W-1:0]   i_read_data,
    output logic                                    o_req_ready,
    output logic                                    o_pe_valid,
    output logic [fiber_bank_geom_pkg::DATA_W-1:0]  o_pe_data,
    output logic                                    o_dram_wr_valid,
    output logic [fiber_bank_geom_pkg::DATA_W-1:0]  o_dram_wr_data,
    output logic [fiber_bank_geom_pkg::ADDR_W-1:0]  o_dram_addr,
    output logic                                    o_dram_rd_ready,
    output logic [fiber_bank_geom_pkg::SET_W-1:0]   o_set,
    output logic [fiber_bank_geom_pkg::TAG_W-1:0]   o_tag,
    output logic                                    o_install,
    output fiber_bank_geom_pkg::way_mask_t          o_install_way,
    output logic                                    o_install_dirty,
    output logic                                    o_touch,
    output logic                                    o_touch_dirty,
    output logic                                    o_invalidate,
    output logic                                    o_age,
    output logic                                    o_data_write,
    output fiber_bank_geom_pkg::way_mask_t          o_data_way,
    output logic [fiber_bank_geom_pkg::DATA_W-1:0]  o_data_wdata,
    output fiber_bank_geom_pkg::way_mask_t          o_read_way
);

    import fiber_bank_geom_pkg::*;
    import fiber_bank_proto_pkg::*;

    bank_state_t       state_q;
    bank_state_t       state_d;
    req_op_t           op_q;
    logic [ADDR_W-1:0] addr_q;
    logic [DATA_W-1:0] data_q;
    way_mask_t         victim_q;
    logic [TAG_W-1:0]  victim_tag_q;
    logic [DATA_W-1:0] resp_q;
    way_mask_t         way_sel;

    // --------------------------------------------------
    // FSM
    // --------------------------------------------------
    always_comb begin
        state_d      = state_q;
        o_install    = 1'b0;
        o_touch      = 1'b0;
        o_invalidate = 1'b0;
        o_age        = 1'b0;
        o_data_write = 1'b0;
        case (state_q)
            ST_IDLE: begin
                if (i_req_valid) begin
                    state_d = ST_LOOKUP;
                end
            end
            ST_LOOKUP: begin
                if (i_hit) begin
                    o_touch      = (op_q != OP_CONSUME);
                    o_data_write = (op_q == OP_WRITE);
                    state_d      = (op_q == OP_WRITE) ? ST_IDLE : ST_RESPOND;
                end else if (op_q == OP_CONSUME) begin
                    // no allocation on a consume miss
                    state_d = ST_FILL;
                end else begin
                    o_age = 1'b1;
                    if (i_victim_dirty) begin
                        state_d = ST_WRITEBACK;
                    end else if (op_q == OP_FETCH) begin
                        state_d = ST_FILL;
                    end else begin
                        o_install    = 1'b1;
                        o_data_write = 1'b1;
                        state_d      = ST_IDLE;
                    end
                end
            end
            ST_WRITEBACK: begin
                if (i_dram_wr_ready) begin
                    if (op_q == OP_WRITE) begin
                        o_install    = 1'b1;
                        o_data_write = 1'b1;
                        state_d      = ST_IDLE;
                    end else begin
                        state_d = ST_FILL;
                    end
                end
            end
            ST_FILL: begin
                if (i_dram_rd_valid) begin
                    o_install    = (op_q == OP_FETCH);
                    o_data_write = (op_q == OP_FETCH);
                    state_d      = ST_RESPOND;
                end
            end
            ST_RESPOND: begin
                if (i_pe_ready) begin
                    // only a consume hit still matches here
                    o_invalidate = (op_q == OP_CONSUME);
                    state_d      = ST_IDLE;
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // --------------------------------------------------
    // request, victim and response registers
    // --------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (o_req_ready && i_req_valid) begin
            op_q   <= i_req_op;
            addr_q <= i_req_addr;
            data_q <= i_req_data;
        end
        if (state_q == ST_LOOKUP) begin
            victim_q     <= i_victim_way;
            victim_tag_q <= i_victim_tag;
            resp_q       <= i_read_data;
        end
        if (o_dram_rd_ready && i_dram_rd_valid) begin
            resp_q <= i_dram_rd_data;
        end
    end

    // hit way or fresh victim during lookup, latched victim later
    assign way_sel = (state_q == ST_LOOKUP) ? (i_hit ? i_hit_way : i_victim_way) : victim_q;

    assign o_set           = addr_q[SET_W-1:0];
    assign o_tag           = addr_q[ADDR_W-1:SET_W];
    assign o_install_way   = way_sel;
    assign o_install_dirty = (op_q == OP_WRITE);
    assign o_touch_dirty   = (op_q == OP_WRITE);
    assign o_data_way      = way_sel;
    assign o_read_way      = way_sel;
    assign o_data_wdata    = (state_q == ST_FILL) ? i_dram_rd_data : data_q;

    // handshake outputs
    assign o_req_ready     = (state_q == ST_IDLE);
    assign o_pe_valid      = (state_q == ST_RESPOND);
    assign o_pe_data       = resp_q;
    assign o_dram_wr_valid = (state_q == ST_WRITEBACK);
    assign o_dram_wr_data  = i_read_data;
    assign o_dram_rd_ready = (state_q == ST_FILL);
    // victim address rebuilt from its tag and the set
    assign o_dram_addr = (state_q == ST_WRITEBACK) ? {victim_tag_q, o_set} : addr_q;

    a_wr_hold: assert property (
        @(posedge i_clk) disable iff (i_reset)
        o_dram_wr_valid && !i_dram_wr_ready |=>
            o_dram_wr_valid && $stable(o_dram_wr_data) && $stable(o_dram_addr)
    );

    a_pe_hold: assert property (
        @(posedge i_clk) disable iff (i_reset)
        o_pe_valid && !i_pe_ready |=> o_pe_valid && $stable(o_pe_data)
    );

endmodule

`default_nettype wire

// ==== src/fiber_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

module fiber_bank (
    input  wire                                     i_clk,
    input  wire                                     i_reset,
    input  wire                                     i_req_valid,
    input  wire fiber_bank_proto_pkg::req_op_t      i_req_op,
    input  wire [fiber_bank_geom_pkg::ADDR_W-1:0]   i_req_addr,
    input  wire [fiber_bank_geom_pkg::DATA_W-1:0]   i_req_data,
    output wire                                     o_req_ready,
    output wire                                     o_pe_valid,
    output wire [fiber_bank_geom_pkg::DATA_W-1:0]   o_pe_data,
    input  wire                                     i_pe_ready,
    output wire                                     o_dram_wr_valid,
    output wire [fiber_bank_geom_pkg::ADDR_W-1:0]   o_dram_addr,
    output wire [fiber_bank_geom_pkg::DATA_W-1:0]   o_dram_wr_data,
    input  wire                                     i_dram_wr_ready,
    output wire                                     o_dram_rd_ready,
    input  wire                                     i_dram_rd_valid,
    input  wire [fiber_bank_geom_pkg::DATA_W-1:0]   i_dram_rd_data
);

    import fiber_bank_geom_pkg::*;

    // --------------------------------------------------
    // controller to storage
    // --------------------------------------------------
    wire [SET_W-1:0]  set;
    wire [TAG_W-1:0]  tag;
    wire              install;
    way_mask_t        install_way;
    wire              install_dirty;
    wire              touch;
    wire              touch_dirty;
    wire              invalidate;
    wire              age;
    wire              data_write;
    way_mask_t        data_way;
    wire [DATA_W-1:0] data_wdata;
    way_mask_t        read_way;

    // storage to controller
    wire              hit;
    way_mask_t        hit_way;
    way_mask_t        victim_way;
    wire              victim_dirty;
    wire [TAG_W-1:0]  victim_tag;
    wire [DATA_W-1:0] read_data;

    bank_controller u_ctrl (
        .i_clk           (i_clk),
        .i_reset         (i_reset),
        .i_req_valid     (i_req_valid),
        .i_req_op        (i_req_op),
        .i_req_addr      (i_req_addr),
        .i_req_data      (i_req_data),
        .i_pe_ready      (i_pe_ready),
        .i_dram_wr_ready (i_dram_wr_ready),
        .i_dram_rd_valid (i_dram_rd_valid),
        .i_dram_rd_data  (i_dram_rd_data),
        .i_hit           (hit),
        .i_hit_way       (hit_way),
        .i_victim_way    (victim_way),
        .i_victim_dirty  (victim_dirty),
        .i_victim_tag    (victim_tag),
        .i_read_data     (read_data),
        .o_req_ready     (o_req_ready),
        .o_pe_valid      (o_pe_valid),
        .o_pe_data       (o_pe_data),
        .o_dram_wr_valid (o_dram_wr_valid),
        .o_dram_wr_data  (o_dram_wr_data),
        .o_dram_addr     (o_dram_addr),
        .o_dram_rd_ready (o_dram_rd_ready),
        .o_set           (set),
        .o_tag           (tag),
        .o_install       (install),
        .o_install_way   (install_way),
        .o_install_dirty (install_dirty),
        .o_touch         (touch),
        .o_touch_dirty   (touch_dirty),
        .o_invalidate    (invalidate),
        .o_age           (age),
        .o_data_write    (data_write),
        .o_data_way      (data_way),
        .o_data_wdata    (data_wdata),
        .o_read_way      (read_way)
    );

    tag_store u_tags (
        .i_clk           (i_clk),
        .i_reset         (i_reset),
        .i_set           (set),
        .i_tag           (tag),
        .i_install       (install),
        .i_install_way   (install_way),
        .i_install_dirty (install_dirty),
        .i_touch         (touch),
        .i_touch_dirty   (touch_dirty),
        .i_invalidate    (invalidate),
        .i_age           (age),
        .o_hit           (hit),
        .o_hit_way       (hit_way),
        .o_victim_way    (victim_way),
        .o_victim_dirty  (victim_dirty),
        .o_victim_tag    (victim_tag)
    );

    data_store u_data (
        .i_clk        (i_clk),
        .i_set        (set),
        .i_write      (data_write),
        .i_write_way  (data_way),
        .i_write_data (data_wdata),
        .i_read_way   (read_way),
        .o_read_data  (read_data)
    );

endmodule

`default_nettype wire

// ==== bench/fiber_bank_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module fiber_bank_tb;

    import fiber_bank_geom_pkg::*;
    import fiber_bank_proto_pkg::*;

    localparam int WAIT_LIMIT = 300;
    localparam int RANDOM_OPS = 400;

    integer seed = 32'h3ce9_eccd;

    logic              i_clk;
    logic              i_reset;
    logic              i_req_valid;
    req_op_t           i_req_op;
    logic [ADDR_W-1:0] i_req_addr;
    logic [DATA_W-1:0] i_req_data;
    logic              i_pe_ready;
    logic              i_dram_wr_ready;
    logic              i_dram_rd_valid;
    logic [DATA_W-1:0] i_dram_rd_data;
    wire               o_req_ready;
    wire               o_pe_valid;
    wire [DATA_W-1:0]  o_pe_data;
    wire               o_dram_wr_valid;
    wire [ADDR_W-1:0]  o_dram_addr;
    wire [DATA_W-1:0]  o_dram_wr_data;
    wire               o_dram_rd_ready;

    // reference models, indexed by word address
    logic [DATA_W-1:0] dram_mem   [0:65535];
    logic [DATA_W-1:0] golden_mem [0:65535];
    logic              gone_mem   [0:65535];
    logic [ADDR_W-1:0] cur_addr;
    wire  [DATA_W-1:0] pe_expect;
    wire  [DATA_W-1:0] wb_expect;
    wire               refetch_acc;

    fiber_bank dut (
        .i_clk           (i_clk),
        .i_reset         (i_reset),
        .i_req_valid     (i_req_valid),
        .i_req_op        (i_req_op),
        .i_req_addr      (i_req_addr),
        .i_req_data      (i_req_data),
        .o_req_ready     (o_req_ready),
        .o_pe_valid      (o_pe_valid),
        .o_pe_data       (o_pe_data),
        .i_pe_ready      (i_pe_ready),
        .o_dram_wr_valid (o_dram_wr_valid),
        .o_dram_addr     (o_dram_addr),
        .o_dram_wr_data  (o_dram_wr_data),
        .i_dram_wr_ready (i_dram_wr_ready),
        .o_dram_rd_ready (o_dram_rd_ready),
        .i_dram_rd_valid (i_dram_rd_valid),
        .i_dram_rd_data  (i_dram_rd_data)
    );

    function automatic int unsigned draw(input int unsigned range);
        draw = $unsigned($random(seed)) % range;
    endfunction

    function automatic logic [DATA_W-1:0] fill_pattern(input logic [ADDR_W-1:0] a);
        fill_pattern = {a[7:0], a[15:8]} ^ 16'hc35a;
    endfunction

    task automatic report_mismatch(input string what);
        $display("[FAIL] %0t: %s", $time, what);
        $display("Checks failed");
    endtask

    task automatic report_hang(input string what);
        $display("timeout while waiting for %s", what);
        $display("Checks failed");
    endtask

    initial begin
        i_clk = 1'b0;
        forever #5 i_clk = ~i_clk;
    end

    // --------------------------------------------------
    // DRAM responder and PE ready
    // --------------------------------------------------
    initial begin
        logic              wr_take;
        logic              rd_take;
        logic              rd_want;
        logic [ADDR_W-1:0] bus_addr;
        logic [DATA_W-1:0] bus_data;
        for (int a = 0; a < 65536; a++) begin
            dram_mem[a] = fill_pattern(16'(a));
        end
        i_dram_wr_ready = 1'b0;
        i_dram_rd_valid = 1'b0;
        i_dram_rd_data  = '0;
        i_pe_ready      = 1'b0;
        forever begin
            // sample mid cycle, act on the next edge
            @(negedge i_clk);
            wr_take  = o_dram_wr_valid && i_dram_wr_ready;
            rd_take  = o_dram_rd_ready && i_dram_rd_valid;
            rd_want  = o_dram_rd_ready && !i_dram_rd_valid;
            bus_addr = o_dram_addr;
            bus_data = o_dram_wr_data;
            @(posedge i_clk);
            if (wr_take) begin
                dram_mem[bus_addr] = bus_data;
            end
            i_dram_wr_ready <= (draw(2) == 0);
            i_pe_ready      <= (draw(2) == 0);
            if (rd_take) begin
                i_dram_rd_valid <= 1'b0;
            end else if (rd_want && draw(3) == 0) begin
                i_dram_rd_valid <= 1'b1;
                i_dram_rd_data  <= dram_mem[bus_addr];
            end
        end
    end

    // --------------------------------------------------
    // checks
    // --------------------------------------------------
    assign pe_expect   = golden_mem[cur_addr];
    assign wb_expect   = golden_mem[o_dram_addr];
    assign refetch_acc = o_req_ready && i_req_valid && (i_req_op == OP_FETCH)
                         && gone_mem[i_req_addr];

    a_reset_idle: assert property (@(posedge i_clk)
        $fell(i_reset) |-> o_req_ready && !o_pe_valid && !o_dram_wr_valid && !o_dram_rd_ready
    ) else begin
        report_mismatch("bank not idle right after reset");
        $fatal(1, "reset state");
    end

    a_resp_data: assert property (@(posedge i_clk) disable iff (i_reset)
        o_pe_valid && i_pe_ready |-> o_pe_data == pe_expect
    ) else begin
        report_mismatch($sformatf("response %h for %h, expected %h",
                                  o_pe_data, cur_addr, pe_expect));
        $fatal(1, "response data");
    end

    a_wb_data: assert property (@(posedge i_clk) disable iff (i_reset)
        o_dram_wr_valid |-> o_dram_wr_data == wb_expect
    ) else begin
        report_mismatch($sformatf("write-back %h to %h, expected %h",
                                  o_dram_wr_data, o_dram_addr, wb_expect));
        $fatal(1, "write-back data");
    end

    // a consumed line must miss on the next fetch
    a_consume_gone: assert property (@(posedge i_clk) disable iff (i_reset)
        $past(refetch_acc, 2) |-> o_dram_rd_ready || o_dram_wr_valid
    ) else begin
        report_mismatch("fetch after consume hit a line that should be gone");
        $fatal(1, "consume invalidate");
    end

    a_pe_hold: assert property (@(posedge i_clk) disable iff (i_reset)
        o_pe_valid && !i_pe_ready |=> o_pe_valid && $stable(o_pe_data)
    ) else begin
        report_mismatch("response dropped or changed under back-pressure");
        $fatal(1, "pe hold");
    end

    a_wr_hold: assert property (@(posedge i_clk) disable iff (i_reset)
        o_dram_wr_valid && !i_dram_wr_ready |=>
            o_dram_wr_valid && $stable(o_dram_wr_data) && $stable(o_dram_addr)
    ) else begin
        report_mismatch("write-back dropped or changed under back-pressure");
        $fatal(1, "write-back hold");
    end

    a_rd_hold: assert property (@(posedge i_clk) disable iff (i_reset)
        o_dram_rd_ready && !i_dram_rd_valid |=> o_dram_rd_ready && $stable(o_dram_addr)
    ) else begin
        report_mismatch("fill request dropped or moved before data");
        $fatal(1, "fill hold");
    end

    a_ready_excl: assert property (@(posedge i_clk) disable iff (i_reset)
        o_req_ready |-> !(o_pe_valid || o_dram_wr_valid || o_dram_rd_ready)
    ) else begin
        report_mismatch("request ready while a transfer is pending");
        $fatal(1, "ready overlap");
    end

    // --------------------------------------------------
    // stimulus
    // --------------------------------------------------
    // one request from acceptance until the bank is idle again
    task automatic run_request(input req_op_t op, input logic [ADDR_W-1:0] addr,
                               input logic [DATA_W-1:0] data);
        int waited;
        @(posedge i_clk);
        cur_addr = addr;
        i_req_valid <= 1'b1;
        i_req_op    <= op;
        i_req_addr  <= addr;
        i_req_data  <= data;
        waited = 0;
        @(negedge i_clk);
        while (!o_req_ready) begin
            if (waited >= WAIT_LIMIT) begin
                report_hang("the bank to accept a request");
                $fatal(1, "request not accepted");
            end
            @(negedge i_clk);
            waited++;
        end
        @(posedge i_clk);
        i_req_valid <= 1'b0;
        waited = 0;
        @(negedge i_clk);
        while (!o_req_ready) begin
            if (waited >= WAIT_LIMIT) begin
                report_hang("a request to complete");
                $fatal(1, "request not completed");
            end
            @(negedge i_clk);
            waited++;
        end
        if (op == OP_WRITE) begin
            golden_mem[addr] = data;
            gone_mem[addr]   = 1'b0;
        end else if (op == OP_FETCH) begin
            gone_mem[addr] = 1'b0;
        end else begin
            // a consumed dirty word is dropped and DRAM keeps the older copy
            golden_mem[addr] = dram_mem[addr];
            gone_mem[addr]   = 1'b1;
        end
    endtask

    initial begin
        int unsigned pick;
        req_op_t     op;
        logic [ADDR_W-1:0] addr;
        for (int a = 0; a < 65536; a++) begin
            golden_mem[a] = fill_pattern(16'(a));
            gone_mem[a]   = 1'b0;
        end
        cur_addr    = '0;
        i_reset     = 1'b1;
        i_req_valid = 1'b0;
        i_req_op    = OP_FETCH;
        i_req_addr  = '0;
        i_req_data  = '0;
        repeat (5) @(posedge i_clk);
        i_reset <= 1'b0;

        // cold miss, hit, write then hit
        run_request(OP_FETCH, 16'h0013, 16'h0000);
        run_request(OP_FETCH, 16'h0013, 16'h0000);
        run_request(OP_WRITE, 16'h0013, 16'hbeef);
        run_request(OP_FETCH, 16'h0013, 16'h0000);

        // six dirty tags in set 5 force write-backs
        for (int t = 1; t <= 6; t++) begin
            run_request(OP_WRITE, {8'h00, 4'(t), 4'h5}, 16'(t * 16'h1111));
        end
        for (int t = 1; t <= 6; t++) begin
            run_request(OP_FETCH, {8'h00, 4'(t), 4'h5}, 16'h0000);
        end

        // consume of a dirty hit, a clean hit and a miss
        run_request(OP_WRITE, 16'h0027, 16'h1234);
        run_request(OP_CONSUME, 16'h0027, 16'h0000);
        run_request(OP_FETCH, 16'h0027, 16'h0000);
        run_request(OP_FETCH, 16'h0037, 16'h0000);
        run_request(OP_CONSUME, 16'h0037, 16'h0000);
        run_request(OP_FETCH, 16'h0037, 16'h0000);
        run_request(OP_CONSUME, 16'h0ff7, 16'h0000);
        run_request(OP_FETCH, 16'h0ff7, 16'h0000);

        // random mix crowded into three sets
        for (int n = 0; n < RANDOM_OPS; n++) begin
            pick = draw(8);
            if (pick < 4) begin
                op = OP_FETCH;
            end else if (pick < 7) begin
                op = OP_WRITE;
            end else begin
                op = OP_CONSUME;
            end
            addr = {8'h00, 4'(draw(8)), 4'(draw(3))};
            run_request(op, addr, 16'(draw(65536)));
        end

        repeat (4) @(posedge i_clk);
        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== fiber_bank.f ====
src/fiber_bank_geom_pkg.sv
src/fiber_bank_proto_pkg.sv
src/srrip_victim.sv
src/tag_store.sv
src/data_store.sv
src/bank_controller.sv
src/fiber_bank.sv
bench/fiber_bank_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := fiber_bank_tb
FILELIST  := fiber_bank.f
OBJ_DIR   := obj_dir
SOURCES   := $(wildcard src/*.sv bench/*.sv)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
